// ==== Makefile ====
# Verilator build and run for the tone synthesizer testbench

SIM := obj_dir/Vtb_fm_synth

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fm_synth -f sources.f
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	verilator --lint-only -Wall --timing --top-module fm_synth_top -f sources.f
	verilator --lint-only -Wall --timing --top-module tb_fm_synth -f sources.f

clean:
	rm -rf obj_dir

// ==== bench/tb_fm_synth.sv ====
// testbench for the tone synthesizer top level
// i2s deserializer, register write tasks, assertion checks
// silence, square voice, attenuation, clamping, timer irq
`timescale 1ns/1ps
`default_nettype none

module tb_fm_synth;
    import fm_pkg::*;

    localparam int FRAME_TIMEOUT = 4 * SAMPLE_DIV;        // clk cycles per frame wait
    localparam int SETTLE_FRAMES = 3;                     // pipeline settle after a write
    localparam int FULL_MAX      = 32767;
    localparam int FULL_MIN      = -32768;

    logic               clk;
    logic               arst_n;
    logic               wr_en;
    logic [7:0]         addr;
    logic [7:0]         wr_data;
    logic               i2s_sclk;
    logic               i2s_ws;
    logic               i2s_sd;
    logic               irq;

    integer             seed;                             // $random state
    logic [31:0]        rx_shift;                         // serial bits MSB first
    logic               rx_ws_prev;                       // ws at previous rising sclk
    logic signed [15:0] rx_l;                             // last complete left word
    logic signed [15:0] rx_r;
    int unsigned        frames_seen;                      // frame done count

    fm_synth_top uut (
        .clk(clk), .arst_n(arst_n), .wr_en(wr_en), .addr(addr), .wr_data(wr_data),
        .i2s_sclk(i2s_sclk), .i2s_ws(i2s_ws), .i2s_sd(i2s_sd), .irq(irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                            // 8 ns period
    end

    // i2s receiver closing a frame on the bit where ws falls (right LSB)
    always @(posedge i2s_sclk or negedge arst_n) begin
        if (!arst_n) begin
            rx_shift    <= '0;
            rx_ws_prev  <= 1'b0;
            rx_l        <= '0;
            rx_r        <= '0;
            frames_seen <= 0;
        end else begin
            rx_shift   <= {rx_shift[30:0], i2s_sd};
            rx_ws_prev <= i2s_ws;
            if (rx_ws_prev && !i2s_ws) begin
                rx_l        <= rx_shift[30:15];
                rx_r        <= {rx_shift[14:0], i2s_sd};
                frames_seen <= frames_seen + 1;
            end
        end
    end

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
        $display("STATUS: FAIL");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic report_failure(input string what);
        $display("at t=%0t: %s", $time, what);
        $display("STATUS: FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;                                               // 1 ns past the rising edge
    endtask

    task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
        wr_en   = 1'b1;
        addr    = a;
        wr_data = d;
        next_cycle();
        wr_en   = 1'b0;
    endtask

    task automatic wait_frame_done();
        int unsigned start;
        int          waited;
        start  = frames_seen;
        waited = 0;
        while (frames_seen == start) begin
            if (waited >= FRAME_TIMEOUT) begin
                report_failure("no i2s frame arrived before the timeout");
            end
            next_cycle();
            waited++;
        end
    endtask

    task automatic wait_irq(input logic level, input int limit, output int cycles);
        cycles = 0;
        while (irq !== level) begin
            if (cycles >= limit && level) begin
                report_failure("irq did not rise before the timeout");
            end else if (cycles >= limit) begin
                report_failure("irq did not clear after the irq_rst write");
            end
            next_cycle();
            cycles++;
        end
    endtask

    task automatic check_value(input string name, input int actual, input int expected);
        assert (actual == expected) else report_mismatch(name, expected, actual);
    endtask

    // square output sits on one of two levels
    task automatic check_level(input string name, input int actual, input int hi, input int lo);
        assert (actual == hi || actual == lo)
            else report_mismatch(name, (actual < 0) ? lo : hi, actual);
    endtask

    // fnum 512..767 and block 2..6 give an increment of at least 2048
    task automatic pick_tone(output logic [9:0] fnum, output logic [2:0] block);
        fnum  = 10'd512 + 10'($unsigned($random(seed)) % 256);
        block = 3'd2 + 3'($unsigned($random(seed)) % 5);
    endtask

    task automatic program_voice(input int v, input logic [9:0] fnum, input logic [2:0] block,
                                 input logic kon, input logic [2:0] atten);
        write_reg(ADDR_VOICE_CFG + 8'(v), {2'b00, 2'(WAVE_SQUARE), 1'b0, atten});
        write_reg(ADDR_FNUM_LO + 8'(v), fnum[7:0]);
        write_reg(ADDR_KEY_BLOCK + 8'(v), {kon, block, 2'b00, fnum[9:8]});
    endtask

    initial begin
        logic [9:0] fnum;
        logic [2:0] block;
        int         cycles;
        bit         seen_max;
        bit         seen_min;
        seed    = 59417;
        arst_n  = 1'b0;
        wr_en   = 1'b0;
        addr    = '0;
        wr_data = '0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        for (int i = 0; i < 8; i++) begin                 // all voices off
            wait_frame_done();
            check_value("i2s left word", rx_l, 0);
            check_value("i2s right word", rx_r, 0);
        end

        pick_tone(fnum, block);
        program_voice(0, fnum, block, 1'b1, 3'd0);
        repeat (SETTLE_FRAMES) wait_frame_done();
        seen_max = 1'b0;
        seen_min = 1'b0;
        for (int i = 0; i < 32; i++) begin
            wait_frame_done();
            check_level("i2s left word", rx_l, FULL_MAX, FULL_MIN);
            check_value("i2s right word", rx_r, 0);
            seen_max |= (rx_l == FULL_MAX);
            seen_min |= (rx_l == FULL_MIN);
        end
        assert (seen_max && seen_min)
            else report_failure("left square never showed both levels");

        pick_tone(fnum, block);
        program_voice(1, fnum, block, 1'b1, 3'd3);        // shift by 3
        write_reg(ADDR_KEY_BLOCK, 8'h00);                 // voice 0 off
        repeat (SETTLE_FRAMES) wait_frame_done();
        for (int i = 0; i < 32; i++) begin
            wait_frame_done();
            check_level("i2s right word", rx_r, 4095, -4096);
            check_value("i2s left word", rx_l, 0);
        end

        write_reg(ADDR_KEY_BLOCK + 8'd1, 8'h00);
        pick_tone(fnum, block);
        program_voice(0, fnum, block, 1'b0, 3'd0);
        program_voice(2, fnum, block, 1'b0, 3'd0);
        wait_frame_done();                                // next tick far away
        write_reg(ADDR_KEY_BLOCK, {1'b1, block, 2'b00, fnum[9:8]});
        write_reg(ADDR_KEY_BLOCK + 8'd2, {1'b1, block, 2'b00, fnum[9:8]});
        repeat (SETTLE_FRAMES) wait_frame_done();
        for (int i = 0; i < 32; i++) begin
            wait_frame_done();
            check_level("i2s left word", rx_l, FULL_MAX, FULL_MIN);  // saturated sum
            check_value("i2s right word", rx_r, 0);
        end

        check_value("irq", irq, 0);                       // timer never started yet
        write_reg(ADDR_TIMER_PRESET, 8'hFC);
        write_reg(ADDR_TIMER_CTRL, 8'h01);
        wait_irq(1'b1, 10 * SAMPLE_DIV, cycles);
        for (int i = 0; i < 8; i++) begin                 // sticky until cleared
            next_cycle();
            check_value("irq", irq, 1);
        end
        write_reg(ADDR_TIMER_CTRL, 8'h80);                // irq clear with start left set
        wait_irq(1'b0, 2, cycles);
        wait_irq(1'b1, 10 * SAMPLE_DIV, cycles);
        assert (cycles >= 3 * SAMPLE_DIV)
            else report_failure("irq came back before the next timer overflow");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
src/fm_pkg.sv
src/voice_if.sv
src/reg_file.sv
src/sample_clk_div.sv
src/voice_bank.sv
src/stereo_mixer.sv
src/i2s_tx.sv
src/irq_timer.sv
src/fm_synth_top.sv
bench/tb_fm_synth.sv

// ==== src/fm_pkg.sv ====
// shared sizes for the tone synthesizer
// host register map base addresses
// waveform select encoding
`default_nettype none

package fm_pkg;

    localparam int NUM_VOICES    = 4;                     // voices in the bank
    localparam int SAMPLE_WIDTH  = 16;                    // signed output sample
    localparam int FNUM_WIDTH    = 10;                    // frequency number
    localparam int BLOCK_WIDTH   = 3;                     // octave shift
    localparam int ATTEN_WIDTH   = 3;                     // arithmetic shift right
    localparam int PHASE_WIDTH   = 16;                    // phase accumulator
    localparam int REG_WIDTH     = 8;                     // host addr and data bus
    localparam int TIMER_WIDTH   = 8;                     // irq timer counter

    localparam int SAMPLE_DIV    = 64;                    // clk cycles per sample
    localparam int DIV_CNT_WIDTH = $clog2(SAMPLE_DIV);    // also one i2s frame

    // register bases, voice n sits at base + n
    localparam logic [REG_WIDTH-1:0] ADDR_FNUM_LO      = 8'h00;
    localparam logic [REG_WIDTH-1:0] ADDR_KEY_BLOCK    = 8'h10;
    localparam logic [REG_WIDTH-1:0] ADDR_VOICE_CFG    = 8'h20;
    localparam logic [REG_WIDTH-1:0] ADDR_TIMER_PRESET = 8'h30;
    localparam logic [REG_WIDTH-1:0] ADDR_TIMER_CTRL   = 8'h31;

    typedef enum logic [1:0] {
        WAVE_SQUARE   = 2'd0,                             // code 3 also plays square
        WAVE_SAW      = 2'd1,
        WAVE_TRIANGLE = 2'd2
    } wave_t;

endpackage

`default_nettype wire

// ==== src/fm_synth_top.sv ====
// synthesizer top level
// register file, sample divider, voice bank, mixer
// i2s output and interrupt timer
`timescale 1ns/1ps
`default_nettype none

module fm_synth_top (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         wr_en,
    input  logic [fm_pkg::REG_WIDTH-1:0] addr,
    input  logic [fm_pkg::REG_WIDTH-1:0] wr_data,
    output logic                         i2s_sclk,
    output logic                         i2s_ws,
    output logic                         i2s_sd,
    output logic                         irq
);
    import fm_pkg::*;

    logic                           sample_en;            // one pulse per sample
    logic [TIMER_WIDTH-1:0]         timer_preset;
    logic                           timer_start;
    logic                           irq_rst;
    logic signed [SAMPLE_WIDTH-1:0] voice_out [NUM_VOICES];
    logic signed [SAMPLE_WIDTH-1:0] sample_l;             // clamped mix
    logic signed [SAMPLE_WIDTH-1:0] sample_r;

    voice_if vif ();

    reg_file u_reg_file (
        .clk(clk), .arst_n(arst_n), .wr_en(wr_en), .addr(addr), .wr_data(wr_data),
        .vp(vif.regs), .timer_preset(timer_preset), .timer_start(timer_start),
        .irq_rst(irq_rst)
    );

    sample_clk_div u_sample_clk_div (.clk(clk), .arst_n(arst_n), .sample_en(sample_en));

    voice_bank u_voice_bank (
        .clk(clk), .arst_n(arst_n), .sample_en(sample_en), .vp(vif.voices),
        .voice_out(voice_out)
    );

    stereo_mixer u_stereo_mixer (
        .clk(clk), .arst_n(arst_n), .voice_out(voice_out),
        .sample_l(sample_l), .sample_r(sample_r)
    );

    i2s_tx u_i2s_tx (
        .clk(clk), .arst_n(arst_n), .sample_en(sample_en),
        .sample_l(sample_l), .sample_r(sample_r),
        .i2s_sclk(i2s_sclk), .i2s_ws(i2s_ws), .i2s_sd(i2s_sd)
    );

    irq_timer u_irq_timer (
        .clk(clk), .arst_n(arst_n), .sample_en(sample_en), .timer_preset(timer_preset),
        .timer_start(timer_start), .irq_rst(irq_rst), .irq(irq)
    );

endmodule

`default_nettype wire

// ==== src/i2s_tx.sv ====
// i2s transmitter, sclk at clk/2, 32 bit clocks per frame
// left word while ws low, right while ws high, MSB first
// data lags ws by one bit clock, changes on falling sclk
`timescale 1ns/1ps
`default_nettype none

module i2s_tx (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   sample_en,
    input  logic signed [fm_pkg::SAMPLE_WIDTH-1:0] sample_l,
    input  logic signed [fm_pkg::SAMPLE_WIDTH-1:0] sample_r,
    output logic                                   i2s_sclk,
    output logic                                   i2s_ws,
    output logic                                   i2s_sd
);
    import fm_pkg::*;

    logic                      active;                    // first frame started
    logic [DIV_CNT_WIDTH-1:0]  cnt;                       // clk index within frame
    logic [DIV_CNT_WIDTH-1:0]  nxt;
    logic [2*SAMPLE_WIDTH-1:0] sr;                        // left then right

    assign nxt = cnt + 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active   <= 1'b0;
            cnt      <= '0;
            sr       <= '0;
            i2s_sclk <= 1'b0;
            i2s_ws   <= 1'b0;
            i2s_sd   <= 1'b0;
        end else if (sample_en) begin
            active   <= 1'b1;
            cnt      <= '0;
            i2s_sclk <= 1'b0;                             // falling edge, slot 0
            i2s_ws   <= 1'b0;
            i2s_sd   <= sr[2*SAMPLE_WIDTH-1];             // right LSB of last frame
            sr       <= {sample_l, sample_r};
        end else if (active) begin
            cnt      <= nxt;
            i2s_sclk <= nxt[0];
            if (!nxt[0]) begin                            // falling sclk, next slot
                i2s_ws <= nxt[DIV_CNT_WIDTH-1];           // high for second half
                i2s_sd <= sr[2*SAMPLE_WIDTH-1];
                sr     <= sr << 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/irq_timer.sv ====
// sample-tick interrupt timer
// counts up from preset while started, reloads on overflow
// sticky irq cleared only by irq_rst
`timescale 1ns/1ps
`default_nettype none

module irq_timer (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           sample_en,
    input  logic [fm_pkg::TIMER_WIDTH-1:0] timer_preset,
    input  logic                           timer_start,
    input  logic                           irq_rst,
    output logic                           irq
);
    import fm_pkg::*;

    logic [TIMER_WIDTH-1:0] count;
    logic                   wrap;                         // overflow this tick

    assign wrap = sample_en && timer_start && (count == '1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (!timer_start) begin
            count <= timer_preset;                        // idle, track preset
        end else if (sample_en) begin
            count <= wrap ? timer_preset : count + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            irq <= 1'b0;
        end else if (wrap) begin
            irq <= 1'b1;                                  // new overflow wins over clear
        end else if (irq_rst) begin
            irq <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
// host register file
// decodes strobed writes into voice parameters and timer controls
// irq_rst is a registered one-cycle pulse
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           wr_en,
    input  logic [fm_pkg::REG_WIDTH-1:0]   addr,
    input  logic [fm_pkg::REG_WIDTH-1:0]   wr_data,
    voice_if.regs                          vp,
    output logic [fm_pkg::TIMER_WIDTH-1:0] timer_preset,
    output logic                           timer_start,
    output logic                           irq_rst
);
    import fm_pkg::*;

    logic ctrl_wr;                                        // write to timer control

    assign ctrl_wr = wr_en && (addr == ADDR_TIMER_CTRL);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_VOICES; i++) begin
                vp.fnum[i]  <= '0;
                vp.block[i] <= '0;
                vp.kon[i]   <= 1'b0;                      // all voices silent
                vp.atten[i] <= '0;
                vp.wave[i]  <= WAVE_SQUARE;
            end
            timer_preset <= '0;
            timer_start  <= 1'b0;
            irq_rst      <= 1'b0;
        end else begin
            irq_rst <= ctrl_wr && wr_data[7];             // high for one cycle only
            if (wr_en) begin
                for (int i = 0; i < NUM_VOICES; i++) begin
                    if (addr == ADDR_FNUM_LO + REG_WIDTH'(i)) begin
                        vp.fnum[i][7:0] <= wr_data;       // fnum low byte
                    end
                    if (addr == ADDR_KEY_BLOCK + REG_WIDTH'(i)) begin
                        vp.kon[i]                  <= wr_data[7];
                        vp.block[i]                <= wr_data[6:4];
                        vp.fnum[i][FNUM_WIDTH-1:8] <= wr_data[1:0];
                    end
                    if (addr == ADDR_VOICE_CFG + REG_WIDTH'(i)) begin
                        vp.atten[i] <= wr_data[2:0];
                        vp.wave[i]  <= wave_t'(wr_data[5:4]);
                    end
                end
                if (addr == ADDR_TIMER_PRESET) begin
                    timer_preset <= wr_data;
                end
            end
            if (ctrl_wr && !wr_data[7]) begin
                timer_start <= wr_data[0];                // irq clear leaves start alone
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/sample_clk_div.sv ====
// sample rate time base
// one-cycle sample_en pulse every SAMPLE_DIV clocks
`timescale 1ns/1ps
`default_nettype none

module sample_clk_div (
    input  logic clk,
    input  logic arst_n,
    output logic sample_en
);
    import fm_pkg::*;

    logic [DIV_CNT_WIDTH-1:0] cnt;                        // position in sample period

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt       <= '0;
            sample_en <= 1'b0;
        end else if (cnt == DIV_CNT_WIDTH'(SAMPLE_DIV - 1)) begin
            cnt       <= '0;
            sample_en <= 1'b1;                            // first pulse SAMPLE_DIV after reset
        end else begin
            cnt       <= cnt + 1'b1;
            sample_en <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/stereo_mixer.sv ====
// stereo mixer, voices 0 and 2 left, 1 and 3 right
// widened sum stage then saturating clamp stage
`timescale 1ns/1ps
`default_nettype none

module stereo_mixer (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic signed [fm_pkg::SAMPLE_WIDTH-1:0] voice_out [fm_pkg::NUM_VOICES],
    output logic signed [fm_pkg::SAMPLE_WIDTH-1:0] sample_l,
    output logic signed [fm_pkg::SAMPLE_WIDTH-1:0] sample_r
);
    import fm_pkg::*;

    logic signed [SAMPLE_WIDTH:0] sum_l;                  // one guard bit
    logic signed [SAMPLE_WIDTH:0] sum_r;

    // top two bits differ only when the sum left the 16-bit range
    function automatic logic signed [SAMPLE_WIDTH-1:0] clamp(
        input logic signed [SAMPLE_WIDTH:0] s
    );
        if (s[SAMPLE_WIDTH] != s[SAMPLE_WIDTH-1]) begin
            clamp = {s[SAMPLE_WIDTH], {(SAMPLE_WIDTH-1){~s[SAMPLE_WIDTH]}}};
        end else begin
            clamp = s[SAMPLE_WIDTH-1:0];
        end
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum_l    <= '0;
            sum_r    <= '0;
            sample_l <= '0;
            sample_r <= '0;
        end else begin
            sum_l    <= voice_out[0] + voice_out[2];     // the analog DAC sum, done digitally
            sum_r    <= voice_out[1] + voice_out[3];
            sample_l <= clamp(sum_l);
            sample_r <= clamp(sum_r);
        end
    end

endmodule

`default_nettype wire

// ==== src/voice_bank.sv ====
// voice bank with one phase accumulator per voice
// square, sawtooth and triangle shaping from the phase
// per-voice attenuation as an arithmetic shift
`timescale 1ns/1ps
`default_nettype none

module voice_bank (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic                                    sample_en,
    voice_if.voices                                 vp,
    output logic signed [fm_pkg::SAMPLE_WIDTH-1:0]  voice_out [fm_pkg::NUM_VOICES]
);
    import fm_pkg::*;

    logic [PHASE_WIDTH-1:0] phase     [NUM_VOICES];       // accumulators
    logic [PHASE_WIDTH-1:0] phase_nxt [NUM_VOICES];       // phase after this tick

    // waveform from the top phase bits
    function automatic logic signed [SAMPLE_WIDTH-1:0] shape(
        input logic [PHASE_WIDTH-1:0] ph,
        input wave_t                  wv
    );
        logic [SAMPLE_WIDTH-1:0] top;
        logic [SAMPLE_WIDTH-2:0] fold;
        top  = ph[PHASE_WIDTH-1 -: SAMPLE_WIDTH];
        fold = top[SAMPLE_WIDTH-1] ? ~top[SAMPLE_WIDTH-2:0] : top[SAMPLE_WIDTH-2:0];
        case (wv)
            WAVE_SAW:      shape = signed'(top);          // ramp wraps max to min
            WAVE_TRIANGLE: shape = {~fold[SAMPLE_WIDTH-2], fold[SAMPLE_WIDTH-3:0], 1'b0};
            default:       shape = {top[SAMPLE_WIDTH-1], {(SAMPLE_WIDTH-1){~top[SAMPLE_WIDTH-1]}}};
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_VOICES; i++) begin
            phase_nxt[i] = phase[i] + (PHASE_WIDTH'(vp.fnum[i]) << vp.block[i]);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_VOICES; i++) begin
                phase[i]     <= '0;
                voice_out[i] <= '0;
            end
        end else if (sample_en) begin
            for (int i = 0; i < NUM_VOICES; i++) begin
                if (vp.kon[i]) begin
                    phase[i]     <= phase_nxt[i];
                    voice_out[i] <= shape(phase_nxt[i], vp.wave[i]) >>> vp.atten[i];
                end else begin
                    phase[i]     <= '0;                   // key off restarts phase
                    voice_out[i] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/voice_if.sv ====
// per-voice parameter bundle
// regs modport drives it, voices modport reads it
`timescale 1ns/1ps
`default_nettype none

interface voice_if;
    import fm_pkg::*;

    logic [FNUM_WIDTH-1:0]  fnum  [NUM_VOICES];           // frequency number
    logic [BLOCK_WIDTH-1:0] block [NUM_VOICES];           // octave
    logic                   kon   [NUM_VOICES];           // key on
    logic [ATTEN_WIDTH-1:0] atten [NUM_VOICES];           // output shift
    wave_t                  wave  [NUM_VOICES];           // waveform select

    modport regs (
        output fnum, block, kon, atten, wave
    );

    modport voices (
        input fnum, block, kon, atten, wave
    );

endinterface

`default_nettype wire
